/* include/pwm_regmap.svh */
`ifndef PWM_REGMAP_SVH
`define PWM_REGMAP_SVH

////////////////////
// word offsets on the wishbone port
////////////////////

`define PWM_REG_CTRL   4'd0  // bit 0 arm, upper bits live generator states
`define PWM_REG_MOTOR0 4'd1  // throttle of motor 0
`define PWM_REG_MOTOR1 4'd2  // throttle of motor 1
`define PWM_REG_MOTOR2 4'd3  // throttle of motor 2
`define PWM_REG_MOTOR3 4'd4  // throttle of motor 3

`endif

/* hdl/drone_pwm_pkg.sv */
package drone_pwm_pkg;

  ////////////////////
  // widths
  ////////////////////

  localparam int NUM_MOTORS = 4;  // quad frame

  typedef logic [15:0] us_count_t;  // microseconds within a frame
  typedef logic [9:0]  motor_val_t; // throttle above the minimum pulse
  typedef logic [31:0] wb_data_t;   // bus data word
  typedef logic [3:0]  wb_addr_t;   // register word address

  ////////////////////
  // generator fsm
  ////////////////////

  typedef enum logic [2:0] {
    min_count = 3'b001,  // guaranteed high time
    pwm_count = 3'b010,  // throttle dependent high time
    low_count = 3'b100   // rest of the frame
  } gen_state_t;

  ////////////////////
  // wishbone classic
  ////////////////////

  typedef struct packed {
    logic     cyc;  // bus cycle in progress
    logic     stb;  // transfer request
    logic     we;   // write when high
    wb_addr_t adr;  // word address
    wb_data_t dat;  // write data
  } wb_req_t;

  typedef struct packed {
    logic     ack;  // one cycle per transfer
    wb_data_t dat;  // read data, valid with ack
  } wb_rsp_t;

endpackage

/* hdl/pwm_timebase.sv */
`timescale 1ns/1ps

module pwm_timebase import drone_pwm_pkg::*; #(
  parameter int PERIOD_US   = 20000,  // frame length in clocks
  parameter int MIN_HIGH_US = 1000    // guaranteed pulse length
) (
  input  logic       us_clk,
  input  logic       resetn,
  output us_count_t  period_count,  // position within the frame
  output motor_val_t high_count,    // position past the minimum pulse
  output logic       frame_start    // high while period_count is zero
);

  localparam us_count_t frame_last = us_count_t'(PERIOD_US - 1);
  localparam us_count_t min_high   = us_count_t'(MIN_HIGH_US);

  us_count_t next_count;  // counter value for the coming cycle

  ////////////////////
  // frame counter
  ////////////////////

  always_comb begin
    if (period_count == frame_last) begin
      next_count = '0;  // wrap at end of frame
    end else begin
      next_count = period_count + 1'b1;
    end
  end

  // high_count is computed from next_count so both registers move together
  always_ff @(posedge us_clk or negedge resetn) begin
    if (!resetn) begin
      period_count <= '0;
      high_count   <= '0;
    end else begin
      period_count <= next_count;
      if (next_count >= min_high) begin
        high_count <= motor_val_t'(next_count - min_high);  // only low bits matter
      end else begin
        high_count <= '0;  // still inside the minimum pulse
      end
    end
  end

  ////////////////////
  // frame strobe
  ////////////////////

  assign frame_start = (period_count == '0);  // one cycle per frame

endmodule

/* hdl/pwm_generator_block.sv */
`timescale 1ns/1ps

module pwm_generator_block import drone_pwm_pkg::*; #(
  parameter int MIN_HIGH_US = 1000,   // guaranteed pulse length
  parameter int MAX_HIGH_US = 2000,   // hard pulse limit
  parameter int PERIOD_US   = 20000   // frame length in clocks
) (
  input  logic       us_clk,
  input  logic       resetn,
  input  logic       armed,         // motor enable for this frame
  input  motor_val_t motor_val,     // shadowed throttle
  input  us_count_t  period_count,  // shared frame position
  input  motor_val_t high_count,    // shared position past min pulse
  output logic       motor_pwm,     // esc drive
  output gen_state_t state          // status for the ctrl read
);

  // last counts of each phase, state changes land on the following clock
  localparam us_count_t min_last   = us_count_t'(MIN_HIGH_US - 1);
  localparam us_count_t max_last   = us_count_t'(MAX_HIGH_US - 1);
  localparam us_count_t frame_last = us_count_t'(PERIOD_US - 1);

  gen_state_t                     next_state;
  logic [$bits(motor_val_t):0]    high_next;    // one bit wider, no wrap
  logic                           val_reached;  // throttle time used up
  logic                           no_pwm_phase; // pulse ends with min part

  assign high_next    = high_count + 1'b1;
  assign val_reached  = (high_next == {1'b0, motor_val});
  assign no_pwm_phase = (motor_val == '0) || (min_last == max_last);

  ////////////////////
  // state register
  ////////////////////

  always_ff @(posedge us_clk or negedge resetn) begin
    if (!resetn) begin
      state <= low_count;  // output off until armed
    end else begin
      state <= next_state;
    end
  end

  always_comb begin
    next_state = state;  // hold by default
    case (state)
      min_count: begin
        if (period_count == min_last) begin
          next_state = no_pwm_phase ? low_count : pwm_count;
        end
      end
      pwm_count: begin
        if (val_reached || (period_count == max_last)) begin
          next_state = low_count;  // throttle time or hard cap
        end
      end
      low_count: begin
        if (period_count == frame_last) begin
          next_state = min_count;  // min_count holds at count 0
        end
      end
      default: next_state = low_count;  // recover from a bad encoding
    endcase
    if (!armed) begin
      next_state = low_count;  // disarmed motors stay off
    end
  end

  // armed also masks the output so a disarm frame shows no edge at count 0
  assign motor_pwm = armed && ((state == min_count) || (state == pwm_count));

endmodule

/* hdl/pwm_wb_regs.sv */
`timescale 1ns/1ps

`include "pwm_regmap.svh"

module pwm_wb_regs import drone_pwm_pkg::*; (
  input  logic                         us_clk,
  input  logic                         resetn,
  input  wb_req_t                      wb_req,       // from the host
  output wb_rsp_t                      wb_rsp,       // to the host
  input  logic                         frame_start,  // shadow load strobe
  input  gen_state_t [NUM_MOTORS-1:0]  gen_state,    // live fsm states
  output logic                         armed,        // arm bit for this frame
  output motor_val_t [NUM_MOTORS-1:0]  motor_val     // throttles for this frame
);

  // generator states sit at the top of the ctrl word
  localparam int state_lsb = $bits(wb_data_t) - NUM_MOTORS * $bits(gen_state_t);

  logic                         arm_live;     // host written arm bit
  logic                         arm_shadow;   // arm bit of the running frame
  motor_val_t [NUM_MOTORS-1:0]  motor_live;   // host written throttles
  motor_val_t [NUM_MOTORS-1:0]  motor_shadow; // throttles of the running frame
  logic                         req_valid;    // cyc and stb both high
  logic                         rearm;        // stb was low since last ack
  logic                         wb_go;        // accept this cycle
  logic                         ack_q;
  wb_data_t                     rd_data;      // read mux
  wb_data_t                     rd_q;         // read data held with ack

  assign req_valid = wb_req.cyc && wb_req.stb;
  assign wb_go     = req_valid && rearm;

  ////////////////////
  // bus handshake
  ////////////////////

  always_ff @(posedge us_clk or negedge resetn) begin
    if (!resetn) begin
      ack_q <= 1'b0;
      rearm <= 1'b1;
    end else begin
      ack_q <= wb_go;  // ack on the clock after the request
      if (wb_go) begin
        rearm <= 1'b0;  // one ack per strobe
      end else if (!req_valid) begin
        rearm <= 1'b1;
      end
    end
  end

  ////////////////////
  // live registers
  ////////////////////

  always_ff @(posedge us_clk or negedge resetn) begin
    if (!resetn) begin
      arm_live   <= 1'b0;
      motor_live <= '0;
    end else if (wb_go && wb_req.we) begin
      if (wb_req.adr == `PWM_REG_CTRL) begin
        arm_live <= wb_req.dat[0];
      end
      for (int k = 0; k < NUM_MOTORS; k++) begin
        if (wb_req.adr == wb_addr_t'(`PWM_REG_MOTOR0 + k)) begin
          motor_live[k] <= motor_val_t'(wb_req.dat);  // upper bits dropped
        end
      end
    end
  end

  // read mux, unmapped words return zero
  always_comb begin
    rd_data = '0;
    if (wb_req.adr == `PWM_REG_CTRL) begin
      rd_data[0] = arm_live;
      for (int k = 0; k < NUM_MOTORS; k++) begin
        rd_data[state_lsb + k * $bits(gen_state_t) +: $bits(gen_state_t)] = gen_state[k];
      end
    end
    for (int k = 0; k < NUM_MOTORS; k++) begin
      if (wb_req.adr == wb_addr_t'(`PWM_REG_MOTOR0 + k)) begin
        rd_data[$bits(motor_val_t)-1:0] = motor_live[k];
      end
    end
  end

  always_ff @(posedge us_clk) begin
    if (wb_go) begin
      rd_q <= rd_data;  // captured with the ack
    end
  end

  assign wb_rsp = '{ack: ack_q, dat: rd_q};

  ////////////////////
  // frame shadows
  ////////////////////

  always_ff @(posedge us_clk or negedge resetn) begin
    if (!resetn) begin
      arm_shadow   <= 1'b0;
      motor_shadow <= '0;
    end else if (frame_start) begin
      arm_shadow   <= arm_live;  // copy at frame boundary only
      motor_shadow <= motor_live;
    end
  end

  // during frame_start the shadow still holds last frame, so the new
  // arm bit is forwarded to cover count 0 of the new frame
  assign armed     = frame_start ? arm_live : arm_shadow;
  assign motor_val = motor_shadow;  // first used at min_last, after the load

endmodule

/* hdl/motor_pwm_top.sv */
`timescale 1ns/1ps

module motor_pwm_top import drone_pwm_pkg::*; #(
  parameter int PERIOD_US   = 20000,  // frame length in clocks
  parameter int MIN_HIGH_US = 1000,   // guaranteed pulse length
  parameter int MAX_HIGH_US = 2000    // hard pulse limit
) (
  input  logic                   us_clk,
  input  logic                   resetn,
  input  wb_req_t                wb_req,
  output wb_rsp_t                wb_rsp,
  output logic [NUM_MOTORS-1:0]  motor_pwm  // one esc line per motor
);

  us_count_t                    period_count;
  motor_val_t                   high_count;
  logic                         frame_start;
  logic                         armed;
  motor_val_t [NUM_MOTORS-1:0]  motor_val;   // shadowed throttles
  gen_state_t [NUM_MOTORS-1:0]  gen_state;   // status back to the bus

  ////////////////////
  // shared timebase
  ////////////////////

  pwm_timebase #(
    .PERIOD_US   (PERIOD_US),
    .MIN_HIGH_US (MIN_HIGH_US)
  ) i_timebase (
    .us_clk       (us_clk),
    .resetn       (resetn),
    .period_count (period_count),
    .high_count   (high_count),
    .frame_start  (frame_start)
  );

  pwm_wb_regs i_wb_regs (
    .us_clk      (us_clk),
    .resetn      (resetn),
    .wb_req      (wb_req),
    .wb_rsp      (wb_rsp),
    .frame_start (frame_start),
    .gen_state   (gen_state),
    .armed       (armed),
    .motor_val   (motor_val)
  );

  ////////////////////
  // one generator per motor
  ////////////////////

  for (genvar k = 0; k < NUM_MOTORS; k++) begin : g_motor
    pwm_generator_block #(
      .MIN_HIGH_US (MIN_HIGH_US),
      .MAX_HIGH_US (MAX_HIGH_US),
      .PERIOD_US   (PERIOD_US)
    ) i_generator (
      .us_clk       (us_clk),
      .resetn       (resetn),
      .armed        (armed),
      .motor_val    (motor_val[k]),
      .period_count (period_count),
      .high_count   (high_count),
      .motor_pwm    (motor_pwm[k]),
      .state        (gen_state[k])
    );
  end

endmodule

/* tb/tb_clk_gen.sv */
`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int PERIOD_NS    = 40,  // 25 MHz stand-in for the us tick
  parameter int RESET_CYCLES = 5
) (
  output logic us_clk,
  output logic resetn
);

  initial begin
    us_clk = 1'b0;
    forever #(PERIOD_NS / 2) us_clk = ~us_clk;
  end

  // release on a falling edge so the first counting edge is clean
  initial begin
    resetn = 1'b0;
    repeat (RESET_CYCLES) @(posedge us_clk);
    @(negedge us_clk);
    resetn = 1'b1;
  end

endmodule

/* tb/motor_pwm_chk.sv */
`timescale 1ns/1ps

module motor_pwm_chk import drone_pwm_pkg::*; #(
  parameter int MAX_HIGH_US = 2000  // hard pulse limit
) (
  input logic                         us_clk,
  input logic                         resetn,
  input logic                         ack,           // wishbone ack
  input gen_state_t [NUM_MOTORS-1:0]  gen_state,     // per motor fsm
  input logic                         armed,         // arm bit seen by generators
  input logic [NUM_MOTORS-1:0]        motor_pwm,
  input us_count_t                    period_count
);

  int assert_fails = 0;  // failed assertion count

  ////////////////////
  // bus
  ////////////////////

  ack_single: assert property (@(posedge us_clk) disable iff (!resetn) ack |=> !ack)
    else begin
      $error("ack high for two cycles in a row");
      assert_fails++;
    end

  ////////////////////
  // generators
  ////////////////////

  for (genvar k = 0; k < NUM_MOTORS; k++) begin : g_onehot
    state_onehot: assert property (@(posedge us_clk) disable iff (!resetn)
      $onehot(gen_state[k]))
      else begin
        $error("generator %0d state is not one-hot", k);
        assert_fails++;
      end
  end

  // a low arm bit holds every fsm in low_count from the next clock
  off_when_disarmed: assert property (@(posedge us_clk) disable iff (!resetn)
    !armed |=> (motor_pwm == '0))
    else begin
      $error("pwm output high after a disarmed cycle");
      assert_fails++;
    end

  // cap ends every pulse one count earlier
  max_high_cap: assert property (@(posedge us_clk) disable iff (!resetn)
    (period_count == us_count_t'(MAX_HIGH_US)) |-> (motor_pwm == '0))
    else begin
      $error("pwm output high past the maximum pulse length");
      assert_fails++;
    end

endmodule

/* tb/tb_motor_pwm.sv */
`timescale 1ns/1ps

`include "pwm_regmap.svh"

module tb_motor_pwm import drone_pwm_pkg::*; ();

  localparam int period_us    = 400;             // short frame
  localparam int min_high_us  = 100;
  localparam int max_high_us  = 200;
  localparam int edge_timeout = 3 * period_us;   // first armed frame has no pulse

  logic                   us_clk;
  logic                   resetn;
  wb_req_t                wb_req;
  wb_rsp_t                wb_rsp;
  logic [NUM_MOTORS-1:0]  motor_pwm;

  int          err_value = 0;     // wrong values
  int          err_other = 0;     // timeouts and missing pulses
  int          cycle = 0;         // falling edges seen
  us_count_t   frame_pos;         // expected timebase position
  motor_val_t  live_val [NUM_MOTORS];  // last written throttles
  logic        live_arm;
  int          rise_total [NUM_MOTORS];
  us_count_t   width_seen [NUM_MOTORS];  // last finished pulse

  tb_clk_gen #(.PERIOD_NS(40), .RESET_CYCLES(5)) i_clk_gen (
    .us_clk (us_clk),
    .resetn (resetn)
  );

  motor_pwm_top #(
    .PERIOD_US   (period_us),
    .MIN_HIGH_US (min_high_us),
    .MAX_HIGH_US (max_high_us)
  ) i_motor_pwm_top (
    .us_clk    (us_clk),
    .resetn    (resetn),
    .wb_req    (wb_req),
    .wb_rsp    (wb_rsp),
    .motor_pwm (motor_pwm)
  );

  bind motor_pwm_top motor_pwm_chk #(.MAX_HIGH_US(MAX_HIGH_US)) i_pwm_chk (
    .us_clk       (us_clk),
    .resetn       (resetn),
    .ack          (wb_rsp.ack),
    .gen_state    (gen_state),
    .armed        (armed),
    .motor_pwm    (motor_pwm),
    .period_count (period_count)
  );

  ////////////////////
  // reference model
  ////////////////////

  always_ff @(posedge us_clk or negedge resetn) begin
    if (!resetn) begin
      frame_pos <= '0;
    end else if (frame_pos == us_count_t'(period_us - 1)) begin
      frame_pos <= '0;  // wrap
    end else begin
      frame_pos <= frame_pos + 1'b1;
    end
  end

  always @(negedge us_clk) begin
    cycle <= cycle + 1;
  end

  function automatic us_count_t expected_width(input motor_val_t v, input logic arm);
    int span;
    int var_part;
    span = max_high_us - min_high_us;
    var_part = (int'(v) > span) ? span : int'(v);  // hard cap
    if (!arm) begin
      return '0;
    end
    return us_count_t'(min_high_us + var_part);
  endfunction

  // ctrl word with every fsm in low_count
  function automatic wb_data_t idle_ctrl_word(input logic arm);
    wb_data_t w;
    int lsb;
    lsb = $bits(wb_data_t) - NUM_MOTORS * $bits(gen_state_t);
    w = '0;
    w[0] = arm;
    for (int k = 0; k < NUM_MOTORS; k++) begin
      w[lsb + k * $bits(gen_state_t) +: $bits(gen_state_t)] = low_count;
    end
    return w;
  endfunction

  function automatic motor_val_t edge_value(input int k);
    case (k)
      0:       return '0;
      1:       return motor_val_t'(max_high_us - min_high_us);      // exactly at cap
      2:       return motor_val_t'(max_high_us - min_high_us + 1);  // just over
      default: return '1;
    endcase
  endfunction

  ////////////////////
  // compare tasks
  ////////////////////

  task automatic check_data(input wb_data_t got, input wb_data_t exp, input string what);
    if (got !== exp) begin
      err_value++;
      $display("[FAIL] %0t %s: got 0x%08h expected 0x%08h", $time, what, got, exp);
    end
  endtask

  task automatic check_width(input us_count_t got, input us_count_t exp, input string what);
    if (got !== exp) begin
      err_value++;
      $display("[FAIL] %0t %s: got %0d expected %0d", $time, what, got, exp);
    end
  endtask

  ////////////////////
  // bus tasks
  ////////////////////

  task automatic wb_access(input wb_addr_t adr, input logic we, input wb_data_t dat,
                           output wb_data_t rdat);
    int waited;
    waited = 0;
    rdat = '0;
    @(negedge us_clk);
    wb_req.cyc = 1'b1;
    wb_req.stb = 1'b1;
    wb_req.we  = we;
    wb_req.adr = adr;
    wb_req.dat = dat;
    do begin
      @(negedge us_clk);
      waited++;
    end while (!wb_rsp.ack && waited < 8);
    if (!wb_rsp.ack) begin
      err_other++;
      $display("no ack from the bus slave for word %0d", adr);
    end else begin
      rdat = wb_rsp.dat;
    end
    wb_req = '0;  // stb low for at least a cycle
  endtask

  task automatic wb_write(input wb_addr_t adr, input wb_data_t dat);
    wb_data_t unused;
    wb_access(adr, 1'b1, dat, unused);
    if (adr == `PWM_REG_CTRL) begin
      live_arm = dat[0];
    end else if (adr >= `PWM_REG_MOTOR0 && adr <= `PWM_REG_MOTOR3) begin
      live_val[int'(adr - `PWM_REG_MOTOR0)] = motor_val_t'(dat);  // 10 bit register
    end
  endtask

  task automatic wb_read(input wb_addr_t adr, output wb_data_t dat);
    wb_access(adr, 1'b0, '0, dat);
  endtask

  // master keeps stb up past the ack and counts the acks it sees
  task automatic held_read(input wb_addr_t adr, input int hold, output int acks);
    acks = 0;
    @(negedge us_clk);
    wb_req.cyc = 1'b1;
    wb_req.stb = 1'b1;
    wb_req.we  = 1'b0;
    wb_req.adr = adr;
    wb_req.dat = '0;
    repeat (hold) begin
      @(negedge us_clk);
      if (wb_rsp.ack) begin
        acks++;
      end
    end
    wb_req = '0;
  endtask

  ////////////////////
  // waits
  ////////////////////

  task automatic wait_pos(input int target);
    int waited;
    waited = 0;
    do begin
      @(negedge us_clk);
      waited++;
    end while (frame_pos != us_count_t'(target) && waited < 2 * period_us);
    if (frame_pos != us_count_t'(target)) begin
      err_other++;
      $display("frame position %0d never reached", target);
    end
  endtask

  task automatic wait_edge(input int k, input logic level);
    int   waited;
    logic last;
    logic hit;
    waited = 0;
    hit = 1'b0;
    last = motor_pwm[k];
    while (!hit && waited < edge_timeout) begin
      @(negedge us_clk);
      waited++;
      hit = (motor_pwm[k] == level) && (last != level);
      last = motor_pwm[k];
    end
    if (!hit) begin
      err_other++;
      $display("missing pulse: motor %0d showed no %s edge within %0d cycles",
               k, level ? "rising" : "falling", edge_timeout);
    end
  endtask

  task automatic last_pulse_is(input int k, input us_count_t exp);
    @(posedge us_clk);  // monitor result settled
    check_width(width_seen[k], exp, $sformatf("motor %0d last pulse", k));
    @(negedge us_clk);
  endtask

  ////////////////////
  // pulse monitors
  ////////////////////

  for (genvar k = 0; k < NUM_MOTORS; k++) begin : g_mon
    logic       prev;
    logic       done;       // pulse just ended
    us_count_t  run_len;
    us_count_t  done_width;
    us_count_t  done_exp;
    us_count_t  snap_exp;   // expected width taken at the rising edge
    int         rises;

    always @(negedge us_clk) begin
      if (!resetn) begin
        prev       <= 1'b0;
        done       <= 1'b0;
        run_len    <= '0;
        done_width <= '0;
        rises      <= 0;
      end else begin
        prev <= motor_pwm[k];
        done <= 1'b0;
        if (motor_pwm[k] && !prev) begin
          run_len  <= 16'd1;
          rises    <= rises + 1;
          snap_exp <= expected_width(live_val[k], live_arm);
          check_width(frame_pos, '0, $sformatf("motor %0d rise position", k));
        end else if (motor_pwm[k]) begin
          run_len <= run_len + 1'b1;
        end else if (prev) begin
          done_width <= run_len;  // falling edge
          done_exp   <= snap_exp;
          done       <= 1'b1;
        end
      end
    end

    // compare half a cycle after the monitor
    always @(posedge us_clk) begin
      if (resetn && done) begin
        check_width(done_width, done_exp, $sformatf("motor %0d pulse width", k));
      end
    end

    assign rise_total[k] = rises;
    assign width_seen[k] = done_width;
  end

  ////////////////////
  // test sequence
  ////////////////////

  initial begin
    wb_data_t rd;
    wb_data_t wr;
    int       waited;
    int       high_cycles;
    int       t0;
    int       fails;
    int       acks;
    int       rises_before [NUM_MOTORS];

    wb_req   = '0;
    live_arm = 1'b0;
    for (int k = 0; k < NUM_MOTORS; k++) begin
      live_val[k] = '0;
    end
    void'($urandom(32'ha1a7_c84a));

    waited = 0;
    while (!resetn && waited < 50) begin
      @(negedge us_clk);
      waited++;
    end
    if (!resetn) begin
      err_other++;
      $display("reset was never released");
    end

    // reset state
    high_cycles = 0;
    repeat (period_us) begin
      @(negedge us_clk);
      if (motor_pwm != '0) begin
        high_cycles++;
      end
    end
    check_width(us_count_t'(high_cycles), '0, "high cycles in first frame");
    wb_read(`PWM_REG_CTRL, rd);
    check_data(rd, idle_ctrl_word(1'b0), "ctrl after reset");
    for (int k = 0; k < NUM_MOTORS; k++) begin
      wb_read(wb_addr_t'(`PWM_REG_MOTOR0 + k), rd);
      check_data(rd, '0, $sformatf("motor %0d after reset", k));
    end
    wb_read(4'd5, rd);
    check_data(rd, '0, "unmapped word 5");
    wb_read(4'd15, rd);
    check_data(rd, '0, "unmapped word 15");

    // one ack per strobe even when the master lingers
    held_read(`PWM_REG_MOTOR0, 4, acks);
    check_data(wb_data_t'(acks), 32'd1, "acks for one held strobe");

    // readback
    for (int round = 0; round < 2; round++) begin
      for (int k = 0; k < NUM_MOTORS; k++) begin
        wr = $urandom;
        wb_write(wb_addr_t'(`PWM_REG_MOTOR0 + k), wr);
      end
      for (int k = 0; k < NUM_MOTORS; k++) begin
        wb_read(wb_addr_t'(`PWM_REG_MOTOR0 + k), rd);
        check_data(rd, wb_data_t'(live_val[k]), $sformatf("motor %0d readback", k));
      end
    end
    wait_pos(period_us / 2);  // stay clear of the shadow load
    wb_write(`PWM_REG_CTRL, 32'h1);
    wb_read(`PWM_REG_CTRL, rd);
    check_data(rd & 32'h1, 32'h1, "arm bit readback");
    wb_write(`PWM_REG_CTRL, 32'h0);
    wb_read(`PWM_REG_CTRL, rd);
    check_data(rd, idle_ctrl_word(1'b0), "ctrl after clearing arm");

    // pulse widths over random and corner values
    for (int round = 0; round < 2; round++) begin
      wait_pos(period_us / 2);
      for (int k = 0; k < NUM_MOTORS; k++) begin
        wr = (round == 0) ? $urandom : wb_data_t'(edge_value(k));
        wb_write(wb_addr_t'(`PWM_REG_MOTOR0 + k), wr);
      end
      wb_write(`PWM_REG_CTRL, 32'h1);
      repeat (3) begin
        wait_edge(0, 1'b1);
        wait_edge(0, 1'b0);
      end
    end
    for (int k = 0; k < NUM_MOTORS; k++) begin
      if (rise_total[k] == 0) begin
        err_other++;
        $display("motor %0d never produced a pulse while armed", k);
      end
    end

    // frame period
    wait_edge(1, 1'b1);
    t0 = cycle;
    wait_edge(1, 1'b1);
    check_width(us_count_t'(cycle - t0), us_count_t'(period_us), "rising edge spacing");

    // update lands on the frame boundary
    wait_pos(period_us / 2);
    wb_write(`PWM_REG_MOTOR2, 32'd80);
    wait_edge(2, 1'b1);
    wait_pos(min_high_us + 20);  // inside the running pulse
    wb_write(`PWM_REG_MOTOR2, 32'd30);
    wait_edge(2, 1'b0);
    last_pulse_is(2, expected_width(10'd80, 1'b1));
    wait_edge(2, 1'b1);
    wait_edge(2, 1'b0);
    last_pulse_is(2, expected_width(10'd30, 1'b1));

    // disarm
    wait_pos(period_us / 2 + 50);
    wb_write(`PWM_REG_CTRL, 32'h0);
    for (int k = 0; k < NUM_MOTORS; k++) begin
      rises_before[k] = rise_total[k];
    end
    repeat (3) begin
      wait_pos(period_us - 1);
    end
    for (int k = 0; k < NUM_MOTORS; k++) begin
      check_data(wb_data_t'(rise_total[k]), wb_data_t'(rises_before[k]),
                 $sformatf("rising edges on motor %0d after disarm", k));
    end
    wb_read(`PWM_REG_CTRL, rd);
    check_data(rd, idle_ctrl_word(1'b0), "ctrl after disarm");

    fails = i_motor_pwm_top.i_pwm_chk.assert_fails;
    $display("errors: value %0d, other %0d, assertion %0d", err_value, err_other, fails);
    if (err_value + err_other + fails == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

/* sim.f */
+incdir+include
hdl/drone_pwm_pkg.sv
hdl/pwm_timebase.sv
hdl/pwm_generator_block.sv
hdl/pwm_wb_regs.sv
hdl/motor_pwm_top.sv
tb/tb_clk_gen.sv
tb/motor_pwm_chk.sv
tb/tb_motor_pwm.sv

/* Bender.yml */
package:
  name: motor_pwm

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hdl/drone_pwm_pkg.sv
      - hdl/pwm_timebase.sv
      - hdl/pwm_generator_block.sv
      - hdl/pwm_wb_regs.sv
      - hdl/motor_pwm_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - tb/tb_clk_gen.sv
      - tb/motor_pwm_chk.sv
      - tb/tb_motor_pwm.sv
